// ==== source/la_params.svh ====
`ifndef LA_PARAMS_SVH
`define LA_PARAMS_SVH

// 256-byte register window
`define LA_BASE_ADR 32'h2200_0000

// 32-bit words in one probe bank
`define LA_BANK_WORDS 4

// flops between pad input and readback
`define LA_SYNC_STAGES 2

`endif

// ==== source/la_bus_pkg.sv ====
`default_nettype none

package la_bus_pkg;

    // wishbone classic slave side
    typedef logic [31:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [3:0]  wb_sel_t;  // one bit per byte lane

endpackage

`default_nettype wire

// ==== source/la_map_pkg.sv ====
`default_nettype none

`include "la_params.svh"

package la_map_pkg;

    typedef logic [7:0] la_offset_t;  // byte offset in window

    typedef enum la_offset_t {
        LA_DATA_0 = 8'h00,
        LA_DATA_1 = 8'h04,
        LA_DATA_2 = 8'h08,
        LA_DATA_3 = 8'h0c,
        LA_ENA_0  = 8'h10,
        LA_ENA_1  = 8'h14,
        LA_ENA_2  = 8'h18,
        LA_ENA_3  = 8'h1c,
        // read only, pin state
        LA_RDBK_0 = 8'h20,
        LA_RDBK_1 = 8'h24,
        LA_RDBK_2 = 8'h28,
        LA_RDBK_3 = 8'h2c
    } la_reg_e;

    // word 0 holds pins 31..0
    typedef logic [`LA_BANK_WORDS-1:0][31:0] la_bank_t;

endpackage

`default_nettype wire

// ==== source/la_wb_frontend.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "la_params.svh"

module la_wb_frontend #(
    parameter la_bus_pkg::wb_addr_t BASE_ADR = `LA_BASE_ADR
) (
    input  logic                   clk,
    input  logic                   resetn,

    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  la_bus_pkg::wb_addr_t   wb_adr_i,
    input  la_bus_pkg::wb_sel_t    wb_sel_i,
    input  la_bus_pkg::wb_data_t   wb_dat_i,
    output la_bus_pkg::wb_data_t   wb_dat_o,
    output logic                   wb_ack_o,

    output logic                   req_valid_o,
    output logic                   req_hit_o,
    output la_map_pkg::la_offset_t req_offset_o,
    output la_bus_pkg::wb_sel_t    req_wstrb_o,
    output la_bus_pkg::wb_data_t   req_wdata_o,

    input  logic                   resp_valid_i,
    input  la_bus_pkg::wb_data_t   resp_rdata_i
);

    import la_bus_pkg::*;
    import la_map_pkg::*;

    localparam int OFS_W = $bits(la_offset_t);

    logic       take;
    logic       busy_q;
    logic       req_valid_q;
    logic       hit_q;
    la_offset_t offset_q;
    wb_sel_t    wstrb_q;
    wb_data_t   wdata_q;

    // one capture per bus cycle
    assign take = wb_cyc_i && wb_stb_i && !busy_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy_q      <= 1'b0;
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= take;
            if (take) begin
                busy_q <= 1'b1;
            end else if (resp_valid_i) begin
                busy_q <= 1'b0;  // free again after the ack cycle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            hit_q    <= (wb_adr_i[31:OFS_W] == BASE_ADR[31:OFS_W]);
            offset_q <= wb_adr_i[OFS_W-1:0];
            wstrb_q  <= wb_sel_i & {$bits(wb_sel_t){wb_we_i}};  // reads carry no strobes
            wdata_q  <= wb_dat_i;
        end
    end

    assign req_valid_o  = req_valid_q;
    assign req_hit_o    = hit_q;
    assign req_offset_o = offset_q;
    assign req_wstrb_o  = wstrb_q;
    assign req_wdata_o  = wdata_q;

    // miss is acked with zero data
    assign wb_ack_o = resp_valid_i;
    assign wb_dat_o = hit_q ? resp_rdata_i : '0;

endmodule

`default_nettype wire

// ==== source/la_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "la_params.svh"

module la_regs (
    input  logic                   clk,
    input  logic                   resetn,

    input  logic                   req_valid_i,
    input  logic                   req_hit_i,
    input  la_map_pkg::la_offset_t req_offset_i,
    input  la_bus_pkg::wb_sel_t    req_wstrb_i,
    input  la_bus_pkg::wb_data_t   req_wdata_i,

    output logic                   resp_valid_o,
    output la_bus_pkg::wb_data_t   resp_rdata_o,

    output la_map_pkg::la_bank_t   data_bank_o,
    output la_map_pkg::la_bank_t   ena_bank_o,
    input  la_map_pkg::la_bank_t   rdbk_bank_i
);

    import la_bus_pkg::*;
    import la_map_pkg::*;

    localparam int IDX_W = $clog2(`LA_BANK_WORDS);

    la_bank_t         data_q;
    la_bank_t         ena_q;
    logic [IDX_W-1:0] word_idx;
    logic             data_sel;
    logic             ena_sel;
    logic             rdbk_sel;
    wb_data_t         rd_word;
    logic             resp_valid_q;
    wb_data_t         rdata_q;

    assign word_idx = req_offset_i[IDX_W+1:2];

    // exact match only, unaligned offsets fall to default
    always_comb begin
        data_sel = 1'b0;
        ena_sel  = 1'b0;
        rdbk_sel = 1'b0;
        case (la_reg_e'(req_offset_i))
            LA_DATA_0, LA_DATA_1, LA_DATA_2, LA_DATA_3: data_sel = 1'b1;
            LA_ENA_0, LA_ENA_1, LA_ENA_2, LA_ENA_3:     ena_sel  = 1'b1;
            LA_RDBK_0, LA_RDBK_1, LA_RDBK_2, LA_RDBK_3: rdbk_sel = 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        rd_word = '0;  // unmapped reads zero
        if (data_sel) begin
            rd_word = data_q[word_idx];
        end else if (ena_sel) begin
            rd_word = ena_q[word_idx];
        end else if (rdbk_sel) begin
            rd_word = rdbk_bank_i[word_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            data_q <= '0;
            ena_q  <= '0;
        end else if (req_valid_i && req_hit_i) begin
            for (int b = 0; b < $bits(wb_sel_t); b++) begin
                if (req_wstrb_i[b]) begin
                    if (data_sel) begin
                        data_q[word_idx][8*b +: 8] <= req_wdata_i[8*b +: 8];
                    end
                    if (ena_sel) begin
                        ena_q[word_idx][8*b +: 8] <= req_wdata_i[8*b +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= req_valid_i;  // never stalls
        end
    end

    // old value on a write, same as the bus sees it
    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            rdata_q <= rd_word;
        end
    end

    assign resp_valid_o = resp_valid_q;
    assign resp_rdata_o = rdata_q;
    assign data_bank_o  = data_q;
    assign ena_bank_o   = ena_q;

endmodule

`default_nettype wire

// ==== source/la_pad_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "la_params.svh"

module la_pad_ctrl #(
    parameter int SYNC_STAGES = `LA_SYNC_STAGES
) (
    input  logic                 clk,
    input  logic                 resetn,

    input  la_map_pkg::la_bank_t data_bank_i,
    input  la_map_pkg::la_bank_t ena_bank_i,

    input  la_map_pkg::la_bank_t la_data_in_i,
    output la_map_pkg::la_bank_t la_data_o,
    output la_map_pkg::la_bank_t la_oe_o,
    output la_map_pkg::la_bank_t rdbk_bank_o
);

    import la_map_pkg::*;

    la_bank_t sync_q [SYNC_STAGES];
    la_bank_t pin_in;

    // pads are async to clk
    always_ff @(posedge clk) begin
        if (!resetn) begin
            sync_q <= '{default: '0};
        end else begin
            sync_q[0] <= la_data_in_i;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign pin_in = sync_q[SYNC_STAGES-1];

    assign la_data_o = data_bank_i;
    assign la_oe_o   = ena_bank_i;  // 1 = drive

    // driven value on outputs, sampled pad on inputs
    assign rdbk_bank_o = (ena_bank_i & data_bank_i) | (~ena_bank_i & pin_in);

endmodule

`default_nettype wire

// ==== source/la_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "la_params.svh"

module la_top (
    input  logic                 clk,
    input  logic                 resetn,

    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  la_bus_pkg::wb_addr_t wb_adr_i,
    input  la_bus_pkg::wb_sel_t  wb_sel_i,
    input  la_bus_pkg::wb_data_t wb_dat_i,
    output la_bus_pkg::wb_data_t wb_dat_o,
    output logic                 wb_ack_o,

    input  la_map_pkg::la_bank_t la_data_in_i,
    output la_map_pkg::la_bank_t la_data_o,
    output la_map_pkg::la_bank_t la_oe_o
);

    import la_bus_pkg::*;
    import la_map_pkg::*;

    logic       req_valid;
    logic       req_hit;
    la_offset_t req_offset;
    wb_sel_t    req_wstrb;
    wb_data_t   req_wdata;
    logic       resp_valid;
    wb_data_t   resp_rdata;
    la_bank_t   data_bank;
    la_bank_t   ena_bank;
    la_bank_t   rdbk_bank;

    la_wb_frontend #(
        .BASE_ADR(`LA_BASE_ADR)
    ) u_frontend (
        .clk          (clk),
        .resetn       (resetn),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_sel_i     (wb_sel_i),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .req_valid_o  (req_valid),
        .req_hit_o    (req_hit),
        .req_offset_o (req_offset),
        .req_wstrb_o  (req_wstrb),
        .req_wdata_o  (req_wdata),
        .resp_valid_i (resp_valid),
        .resp_rdata_i (resp_rdata)
    );

    la_regs u_regs (
        .clk          (clk),
        .resetn       (resetn),
        .req_valid_i  (req_valid),
        .req_hit_i    (req_hit),
        .req_offset_i (req_offset),
        .req_wstrb_i  (req_wstrb),
        .req_wdata_i  (req_wdata),
        .resp_valid_o (resp_valid),
        .resp_rdata_o (resp_rdata),
        .data_bank_o  (data_bank),
        .ena_bank_o   (ena_bank),
        .rdbk_bank_i  (rdbk_bank)
    );

    la_pad_ctrl #(
        .SYNC_STAGES(`LA_SYNC_STAGES)
    ) u_pad_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .data_bank_i  (data_bank),
        .ena_bank_i   (ena_bank),
        .la_data_in_i (la_data_in_i),
        .la_data_o    (la_data_o),
        .la_oe_o      (la_oe_o),
        .rdbk_bank_o  (rdbk_bank)
    );

endmodule

`default_nettype wire

// ==== tests/la_tb_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module la_tb_properties (
    input logic clk,
    input logic resetn,
    input logic cyc_i,
    input logic stb_i,
    input logic ack_i
);

    // ack is a single-cycle pulse
    ack_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
        ack_i |=> !ack_i)
        else $error("wb_ack_o stayed high for more than one cycle");

    ack_after_request: assert property (@(posedge clk) disable iff (!resetn)
        ack_i |-> $past(cyc_i && stb_i))
        else $error("wb_ack_o without cyc and stb in the cycle before");

    // quiet bus while held in reset
    ack_low_in_reset: assert property (@(posedge clk)
        (!resetn && $past(!resetn)) |-> !ack_i)
        else $error("wb_ack_o high during reset");

endmodule

bind la_top la_tb_properties u_props (
    .clk    (clk),
    .resetn (resetn),
    .cyc_i  (wb_cyc_i),
    .stb_i  (wb_stb_i),
    .ack_i  (wb_ack_o)
);

`default_nettype wire

// ==== tests/la_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "la_params.svh"

module la_tb;

    import la_bus_pkg::*;
    import la_map_pkg::*;

    localparam int       CLK_PERIOD   = 100;
    localparam int       RESET_CYCLES = 16;
    localparam int       ACK_LIMIT    = 10;
    localparam int       HOLD_CYCLES  = 10;
    localparam int       SEED         = 75950;
    localparam wb_addr_t BASE_ADR     = `LA_BASE_ADR;
    // 12 + 16 + 32 + 32 + 16
    localparam int       NUM_TXN      = 108;
    localparam int       WATCHDOG_CYC = NUM_TXN * 20;

    logic     clk;
    logic     resetn;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_addr_t wb_adr;
    wb_sel_t  wb_sel;
    wb_data_t wb_dat_w;
    wb_data_t wb_dat_r;
    logic     wb_ack;
    la_bank_t la_data_in;
    la_bank_t la_data;
    la_bank_t la_oe;

    la_bank_t model_data;
    la_bank_t model_ena;
    logic     exp_check;
    wb_data_t exp_rdata;
    int       checks;
    int       errors;
    int       timeouts;

    la_top DUT (
        .clk          (clk),
        .resetn       (resetn),
        .wb_cyc_i     (wb_cyc),
        .wb_stb_i     (wb_stb),
        .wb_we_i      (wb_we),
        .wb_adr_i     (wb_adr),
        .wb_sel_i     (wb_sel),
        .wb_dat_i     (wb_dat_w),
        .wb_dat_o     (wb_dat_r),
        .wb_ack_o     (wb_ack),
        .la_data_in_i (la_data_in),
        .la_data_o    (la_data),
        .la_oe_o      (la_oe)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic in_window(input wb_addr_t adr);
        return adr[31:8] == BASE_ADR[31:8];
    endfunction

    function automatic wb_addr_t word_adr(input int w);
        return BASE_ADR + wb_addr_t'(4 * w);
    endfunction

    // expected read data from the model and the pad inputs
    function automatic wb_data_t ref_read(input wb_addr_t adr);
        logic [7:0] ofs;
        logic [1:0] idx;
        wb_data_t   word;
        int         k;
        ofs  = adr[7:0];
        idx  = ofs[3:2];
        word = '0;
        if (in_window(adr) && ofs[1:0] == 2'b00 && ofs < 8'h30) begin
            case (ofs[5:4])
                2'd0:    word = model_data[idx];
                2'd1:    word = model_ena[idx];
                default: begin
                    for (k = 0; k < 32; k++) begin
                        // enabled pin reads its driven bit
                        word[k] = model_ena[idx][k] ? model_data[idx][k]
                                                    : la_data_in[idx][k];
                    end
                end
            endcase
        end
        return word;
    endfunction

    function automatic void write_model(input wb_addr_t adr, input wb_sel_t sel,
                                        input wb_data_t dat);
        logic [7:0] ofs;
        logic [1:0] idx;
        int         b;
        ofs = adr[7:0];
        idx = ofs[3:2];
        if (!in_window(adr) || ofs[1:0] != 2'b00 || ofs >= 8'h20) begin
            return;  // readback and misses hold nothing
        end
        for (b = 0; b < 4; b++) begin
            if (sel[b]) begin
                if (ofs[4]) begin
                    model_ena[idx][8*b +: 8] = dat[8*b +: 8];
                end else begin
                    model_data[idx][8*b +: 8] = dat[8*b +: 8];
                end
            end
        end
    endfunction

    task automatic bus_cycle(input logic we, input wb_addr_t adr, input wb_sel_t sel,
                             input wb_data_t dat);
        int waited;
        waited = 0;
        @(negedge clk);
        exp_check = !we || !in_window(adr);  // miss writes must return zero too
        exp_rdata = ref_read(adr);
        wb_cyc    = 1'b1;
        wb_stb    = 1'b1;
        wb_we     = we;
        wb_adr    = adr;
        wb_sel    = sel;
        wb_dat_w  = dat;
        @(negedge clk);
        while (!wb_ack && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!wb_ack) begin
            timeouts++;
            $display("no acknowledge within %0d cycles for address %h at %0t",
                     ACK_LIMIT, adr, $time);
        end else if (we) begin
            write_model(adr, sel, dat);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic write_word(input wb_addr_t adr, input wb_sel_t sel, input wb_data_t dat);
        bus_cycle(1'b1, adr, sel, dat);
    endtask

    task automatic read_word(input wb_addr_t adr);
        bus_cycle(1'b0, adr, 4'hf, '0);
    endtask

    // compare on every ack, pins whenever no ack is in flight
    always @(negedge clk) begin
        if (resetn) begin
            if (wb_ack) begin
                if (exp_check) begin
                    checks++;
                    if (wb_dat_r !== exp_rdata) begin
                        errors++;
                        $display("ERROR %0t wb_dat_o exp=%h got=%h", $time, exp_rdata, wb_dat_r);
                    end
                end
            end else begin
                checks++;
                if (la_data !== model_data) begin
                    errors++;
                    $display("ERROR %0t la_data_o exp=%h got=%h", $time, model_data, la_data);
                end
                if (la_oe !== model_ena) begin
                    errors++;
                    $display("ERROR %0t la_oe_o exp=%h got=%h", $time, model_ena, la_oe);
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("watchdog expired after %0d cycles, the test did not finish", WATCHDOG_CYC);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int i;
        int r;
        void'($urandom(SEED));
        resetn     = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_sel     = '0;
        wb_dat_w   = '0;
        la_data_in = '0;
        model_data = '0;
        model_ena  = '0;
        exp_check  = 1'b0;
        exp_rdata  = '0;
        checks     = 0;
        errors     = 0;
        timeouts   = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        resetn = 1'b1;

        for (i = 0; i < 12; i++) read_word(word_adr(i));  // reset values

        for (i = 0; i < 8; i++) write_word(word_adr(i), 4'hf, $urandom);
        for (i = 0; i < 8; i++) read_word(word_adr(i));

        // byte lanes
        for (i = 0; i < 24; i++) begin
            write_word(word_adr($urandom_range(7, 0)), 4'($urandom), $urandom);
        end
        for (i = 0; i < 8; i++) read_word(word_adr(i));

        // mixed inputs and outputs
        for (r = 0; r < 4; r++) begin
            for (i = 4; i < 8; i++) write_word(word_adr(i), 4'hf, $urandom);
            la_data_in = {$urandom, $urandom, $urandom, $urandom};
            repeat (HOLD_CYCLES) @(negedge clk);  // past the synchronizer
            for (i = 8; i < 12; i++) read_word(word_adr(i));
        end

        write_word(BASE_ADR ^ 32'h0100_0000, 4'hf, $urandom);
        read_word(BASE_ADR ^ 32'h0100_0000);
        write_word(BASE_ADR + 32'h0000_0100, 4'hf, $urandom);  // next window up
        read_word(BASE_ADR + 32'h0000_0100);
        for (i = 0; i < 12; i++) read_word(word_adr(i));

        repeat (2) @(negedge clk);
        $display("checks=%0d errors=%0d timeouts=%0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0 && checks > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+source
source/la_bus_pkg.sv
source/la_map_pkg.sv
source/la_wb_frontend.sv
source/la_regs.sv
source/la_pad_ctrl.sv
source/la_top.sv
tests/la_tb_properties.sv
tests/la_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the logic-analyzer testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir

verilator --binary --timing --assert -f project.f --top-module la_tb -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

output=$("./$BUILD_DIR/Vla_tb")
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
